// File: rv_core.f
+incdir+include
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_imm_ext.sv
hdl/rv_datapath.sv
hdl/rv_control.sv
hdl/rv_imem.sv
hdl/rv_dmem.sv
hdl/rv_core.sv
sim/rv_core_props.sv
sim/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module rv_core_tb \
    -f rv_core.f \
    -o rv_core_sim

# the log decides pass or fail
./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "RESULT: PASS" sim.log

// File: sim/rv_core_tb.sv
`timescale 1ns/10ps

`include "rv_settings.svh"

module rv_core_tb;

    localparam int RESET_CYCLES = 16;

    logic                 clk;
    logic                 rst_n;
    logic                 prog_we;
    logic [5:0]           prog_addr;
    logic [`XLEN-1:0]     prog_data;
    logic [`PC_WIDTH-1:0] pc;
    logic                 mem_we;
    logic [`XLEN-1:0]     mem_addr;
    logic [`XLEN-1:0]     mem_wdata;

    // program image and the stores it must produce, in order
    logic [`XLEN-1:0]     prog_q [$];
    logic [`XLEN-1:0]     exp_addr_q [$];
    logic [`XLEN-1:0]     exp_data_q [$];
    string                exp_name_q [$];
    logic                 program_ready = 1'b0;
    logic                 first_cycle = 1'b1;
    int                   store_idx = 0;
    int                   same_pc_cycles = 0;
    logic [`PC_WIDTH-1:0] last_pc = '0;

    rv_core u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    // ------------------------------------------------------------------------
    // rv32i encoders
    // ------------------------------------------------------------------------
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // addi and lw share this layout
    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // sw, word width in funct3
    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // beq, byte offset with bit 0 dropped
    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic expect_store(input string name, input logic [31:0] addr,
                                input logic [31:0] data);
        exp_name_q.push_back(name);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    // ------------------------------------------------------------------------
    // program table with hand-derived store values
    // ------------------------------------------------------------------------
    task automatic build_program();
        logic [11:0] a_imm;
        logic [11:0] b_imm;
        logic [31:0] a_val;
        logic [31:0] b_val;
        logic [31:0] link;
        a_imm = 12'($urandom);
        b_imm = 12'($urandom);
        // addi sign-extends its 12-bit immediate
        a_val = {{20{a_imm[11]}}, a_imm};
        b_val = {{20{b_imm[11]}}, b_imm};
        prog_q.push_back(i_word(a_imm, 5'd0, 3'b000, 5'd1, 7'b0010011));
        prog_q.push_back(i_word(b_imm, 5'd0, 3'b000, 5'd2, 7'b0010011));
        prog_q.push_back(s_word(12'd48, 5'd1, 5'd0));
        expect_store("addi", 32'd48, a_val);
        prog_q.push_back(r_word(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));
        prog_q.push_back(s_word(12'd0, 5'd3, 5'd0));
        expect_store("add", 32'd0, a_val + b_val);
        prog_q.push_back(r_word(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4));
        prog_q.push_back(s_word(12'd4, 5'd4, 5'd0));
        expect_store("sub", 32'd4, a_val - b_val);
        prog_q.push_back(r_word(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd5));
        prog_q.push_back(s_word(12'd8, 5'd5, 5'd0));
        expect_store("and", 32'd8, a_val & b_val);
        prog_q.push_back(r_word(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd6));
        prog_q.push_back(s_word(12'd12, 5'd6, 5'd0));
        expect_store("or", 32'd12, a_val | b_val);
        // x7 = -5, x8 = 7
        prog_q.push_back(i_word(12'hffb, 5'd0, 3'b000, 5'd7, 7'b0010011));
        prog_q.push_back(i_word(12'd7, 5'd0, 3'b000, 5'd8, 7'b0010011));
        prog_q.push_back(r_word(7'b0000000, 5'd8, 5'd7, 3'b010, 5'd9));
        prog_q.push_back(s_word(12'd16, 5'd9, 5'd0));
        expect_store("slt_neg_pos", 32'd16, 32'd1);
        prog_q.push_back(r_word(7'b0000000, 5'd7, 5'd8, 3'b010, 5'd10));
        prog_q.push_back(s_word(12'd20, 5'd10, 5'd0));
        expect_store("slt_pos_neg", 32'd20, 32'd0);
        // reload the sum and copy it elsewhere
        prog_q.push_back(i_word(12'd0, 5'd0, 3'b010, 5'd11, 7'b0000011));
        prog_q.push_back(s_word(12'd24, 5'd11, 5'd0));
        expect_store("lw_round_trip", 32'd24, a_val + b_val);
        prog_q.push_back(i_word(12'd99, 5'd0, 3'b000, 5'd0, 7'b0010011));
        prog_q.push_back(s_word(12'd28, 5'd0, 5'd0));
        expect_store("x0_store", 32'd28, 32'd0);
        // taken beq jumps over a store to 32
        prog_q.push_back(b_word(13'd8, 5'd1, 5'd1));
        prog_q.push_back(s_word(12'd32, 5'd7, 5'd0));
        prog_q.push_back(b_word(13'd8, 5'd8, 5'd7));
        prog_q.push_back(s_word(12'd36, 5'd8, 5'd0));
        expect_store("beq_not_taken", 32'd36, 32'd7);
        // jal over a store to 40, link = own address + 4
        link = 32'(prog_q.size() * 4 + 4);
        prog_q.push_back(j_word(21'd8, 5'd12));
        prog_q.push_back(s_word(12'd40, 5'd7, 5'd0));
        prog_q.push_back(s_word(12'd44, 5'd12, 5'd0));
        expect_store("jal_link", 32'd44, link);
        // halt loop
        prog_q.push_back(j_word(21'd0, 5'd0));
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_store();
        assert (store_idx < exp_addr_q.size()) else
            fail_run($sformatf("store to %h after the last expected store", mem_addr));
        assert (mem_addr == exp_addr_q[store_idx]) else
            fail_run($sformatf("ERR %s address: expected %h actual %h",
                               exp_name_q[store_idx], exp_addr_q[store_idx], mem_addr));
        assert (mem_wdata == exp_data_q[store_idx]) else
            fail_run($sformatf("ERR %s data: expected %h actual %h",
                               exp_name_q[store_idx], exp_data_q[store_idx], mem_wdata));
        store_idx++;
    endtask

    // ------------------------------------------------------------------------
    // clock, load and reset
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        void'($urandom(67));
        build_program();
        program_ready = 1'b1;
        // one word per edge while the core is held
        for (int i = 0; i < prog_q.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 6'(i);
            prog_data <= prog_q[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        // reset held a further 16 cycles past the load
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst_n <= 1'b1;
    end

    // ------------------------------------------------------------------------
    // checks, sampled mid-cycle
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (pc == '0 && !mem_we) else
                fail_run("pc not held at 0, or a store happened, during reset");
            same_pc_cycles = 0;
            last_pc = pc;
        end else begin
            if (first_cycle) begin
                assert (pc == '0 && !mem_we) else
                    fail_run("first cycle after reset did not start at pc 0 without a store");
                first_cycle = 1'b0;
            end
            if (mem_we) begin
                check_store();
            end
            // halt is a jal to itself
            same_pc_cycles = (pc == last_pc) ? same_pc_cycles + 1 : 0;
            last_pc = pc;
            if (same_pc_cycles >= 2) begin
                if (store_idx == exp_addr_q.size()) begin
                    $display("RESULT: PASS");
                    $finish;
                end else begin
                    fail_run($sformatf("halted after %0d of %0d expected stores",
                                       store_idx, exp_addr_q.size()));
                end
            end
        end
    end

    // watchdog, budget scales with program length
    initial begin
        wait (program_ready);
        repeat (prog_q.size() * 4 + 64) @(posedge clk);
        fail_run("timeout: the core never reached its halt loop");
    end

endmodule

// File: sim/rv_core_props.sv
`timescale 1ns/10ps

`include "rv_settings.svh"

module rv_core_props (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`PC_WIDTH-1:0] pc,
    input  logic                 mem_we
);

    // no store strobe while the core is held
    store_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_we)
        else $error("store strobe high while rst_n is low");

    // sync reset clears pc on the next edge
    pc_zero_after_reset: assert property (@(posedge clk) !rst_n |=> (pc == '0))
        else $error("pc not cleared one cycle after reset");

    // pc only ever steps in words
    pc_word_aligned: assert property (@(posedge clk) rst_n |-> (pc[1:0] == 2'b00))
        else $error("pc lost word alignment");

endmodule

// attach to every rv_core
bind rv_core rv_core_props u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .pc     (pc),
    .mem_we (mem_we)
);

// File: hdl/rv_core.sv
`timescale 1ns/10ps

`include "rv_settings.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 prog_we,
    input  logic [5:0]           prog_addr,
    input  logic [`XLEN-1:0]     prog_data,
    output logic [`PC_WIDTH-1:0] pc,
    output logic                 mem_we,
    output logic [`XLEN-1:0]     mem_addr,
    output logic [`XLEN-1:0]     mem_wdata
);

    // ------------------------------------------------------------------------
    // control levels and decoder fields
    // ------------------------------------------------------------------------
    logic             reg_write;
    logic             alu_src;
    logic             branch;
    logic             jump;
    imm_src_e         imm_src;
    result_src_e      result_src;
    alu_op_e          alu_control;
    opcode_e          op;
    logic [2:0]       funct3;
    logic             funct7_5;

    // memory side
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] read_data;

    rv_control u_control (
        .rst_n       (rst_n),
        .op          (op),
        .funct3      (funct3),
        .funct7_5    (funct7_5),
        .reg_write   (reg_write),
        .alu_src     (alu_src),
        .mem_write   (mem_we),
        .branch      (branch),
        .jump        (jump),
        .imm_src     (imm_src),
        .result_src  (result_src),
        .alu_control (alu_control)
    );

    // store port goes straight out for observation
    rv_datapath u_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_write   (reg_write),
        .alu_src     (alu_src),
        .branch      (branch),
        .jump        (jump),
        .imm_src     (imm_src),
        .result_src  (result_src),
        .alu_control (alu_control),
        .instr       (instr),
        .read_data   (read_data),
        .pc          (pc),
        .alu_result  (mem_addr),
        .write_data  (mem_wdata),
        .op          (op),
        .funct3      (funct3),
        .funct7_5    (funct7_5)
    );

    rv_imem u_imem (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .instr     (instr)
    );

    rv_dmem u_dmem (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (read_data)
    );

endmodule

// File: hdl/rv_dmem.sv
`timescale 1ns/10ps

`include "rv_settings.svh"

module rv_dmem (
    input  logic             clk,
    input  logic             we,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rdata
);

    // word index width
    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [AW-1:0]    word_addr;

    // byte address to word index, high bits wrap
    assign word_addr = addr[AW+1:2];

    // store lands on the edge ending the cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_addr] <= wdata;
        end
    end

    // lw sees memory in the same cycle
    assign rdata = mem[word_addr];

endmodule

// File: hdl/rv_imem.sv
`timescale 1ns/10ps

`include "rv_settings.svh"

module rv_imem (
    input  logic                 clk,
    input  logic                 prog_we,
    input  logic [5:0]           prog_addr,
    input  logic [`XLEN-1:0]     prog_data,
    input  logic [`PC_WIDTH-1:0] pc,
    output logic [`XLEN-1:0]     instr
);

    // word index width
    localparam int AW = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0] mem [`IMEM_WORDS];

    // program load, one word per strobe
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // fetch by word, byte offset dropped
    assign instr = mem[pc[AW+1:2]];

endmodule

// File: hdl/rv_control.sv
`timescale 1ns/10ps

module rv_control
    import rv_pkg::*;
(
    input  logic        rst_n,
    input  opcode_e     op,
    input  logic [2:0]  funct3,
    input  logic        funct7_5,
    output logic        reg_write,
    output logic        alu_src,
    output logic        mem_write,
    output logic        branch,
    output logic        jump,
    output imm_src_e    imm_src,
    output result_src_e result_src,
    output alu_op_e     alu_control
);

    // decoded writes before reset gating
    logic    dec_reg_write;
    logic    dec_mem_write;
    // operation picked from the funct fields
    alu_op_e funct_op;

    // ------------------------------------------------------------------------
    // alu decoder, only r-type honours funct7 bit 5
    // ------------------------------------------------------------------------
    always_comb begin
        case (funct3)
            3'b000:  funct_op = (op == op_r && funct7_5) ? alu_sub : alu_add;
            3'b010:  funct_op = alu_slt;
            3'b110:  funct_op = alu_or;
            3'b111:  funct_op = alu_and;
            default: funct_op = alu_add;
        endcase
    end

    // ------------------------------------------------------------------------
    // main decoder
    // ------------------------------------------------------------------------
    always_comb begin
        // defaults, nothing written
        dec_reg_write = 1'b0;
        dec_mem_write = 1'b0;
        alu_src       = 1'b0;
        branch        = 1'b0;
        jump          = 1'b0;
        imm_src       = imm_i;
        result_src    = res_alu;
        alu_control   = alu_add;
        case (op)
            op_r: begin
                dec_reg_write = 1'b1;
                alu_control   = funct_op;
            end
            op_i: begin
                dec_reg_write = 1'b1;
                alu_src       = 1'b1;
                alu_control   = funct_op;
            end
            // address = rs1 + offset
            op_load: begin
                dec_reg_write = 1'b1;
                alu_src       = 1'b1;
                result_src    = res_mem;
            end
            op_store: begin
                dec_mem_write = 1'b1;
                alu_src       = 1'b1;
                imm_src       = imm_s;
            end
            // compare by subtraction
            op_branch: begin
                branch      = 1'b1;
                imm_src     = imm_b;
                alu_control = alu_sub;
            end
            op_jal: begin
                dec_reg_write = 1'b1;
                jump          = 1'b1;
                imm_src       = imm_j;
                result_src    = res_pc4;
            end
            default: ;
        endcase
    end

    // no state changes while held in reset
    assign reg_write = dec_reg_write && rst_n;
    assign mem_write = dec_mem_write && rst_n;

endmodule

// File: hdl/rv_datapath.sv
`timescale 1ns/10ps

`include "rv_settings.svh"

module rv_datapath
    import rv_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 reg_write,
    input  logic                 alu_src,
    input  logic                 branch,
    input  logic                 jump,
    input  imm_src_e             imm_src,
    input  result_src_e          result_src,
    input  alu_op_e              alu_control,
    input  logic [`XLEN-1:0]     instr,
    input  logic [`XLEN-1:0]     read_data,
    output logic [`PC_WIDTH-1:0] pc,
    output logic [`XLEN-1:0]     alu_result,
    output logic [`XLEN-1:0]     write_data,
    output opcode_e              op,
    output logic [2:0]           funct3,
    output logic                 funct7_5
);

    logic [`PC_WIDTH-1:0] pc_next;
    logic [`PC_WIDTH-1:0] pc_plus4;
    logic [`PC_WIDTH-1:0] pc_target;
    logic [`XLEN-1:0]     src_a;
    logic [`XLEN-1:0]     src_b;
    logic [`XLEN-1:0]     imm_ext;
    logic [`XLEN-1:0]     result;
    logic                 zero;

    // ------------------------------------------------------------------------
    // fetch: pc register and next-pc select
    // ------------------------------------------------------------------------
    assign pc_plus4  = pc + `PC_WIDTH'd4;
    // target wraps within the 16-bit address space
    assign pc_target = pc + imm_ext[`PC_WIDTH-1:0];
    // jal always, beq only when operands equal
    assign pc_next   = (jump || (branch && zero)) ? pc_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // ------------------------------------------------------------------------
    // decode and execute
    // ------------------------------------------------------------------------
    rv_regfile u_regfile (
        .clk (clk),
        .we  (reg_write),
        .a1  (instr[19:15]),
        .a2  (instr[24:20]),
        .a3  (instr[11:7]),
        .wd3 (result),
        .rd1 (src_a),
        .rd2 (write_data)
    );

    rv_imm_ext u_imm_ext (
        .instr   (instr),
        .imm_src (imm_src),
        .imm_ext (imm_ext)
    );

    // rs2 or immediate
    assign src_b = alu_src ? imm_ext : write_data;

    rv_alu u_alu (
        .src_a       (src_a),
        .src_b       (src_b),
        .alu_control (alu_control),
        .result      (alu_result),
        .zero        (zero)
    );

    // write-back, pc4 is the jal link address
    always_comb begin
        case (result_src)
            res_mem: result = read_data;
            res_pc4: result = {{(`XLEN-`PC_WIDTH){1'b0}}, pc_plus4};
            default: result = alu_result;
        endcase
    end

    // fields for the decoder
    assign op       = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

endmodule

// File: hdl/rv_imm_ext.sv
`timescale 1ns/10ps

`include "rv_settings.svh"

module rv_imm_ext
    import rv_pkg::*;
(
    input  logic [`XLEN-1:0] instr,
    input  imm_src_e         imm_src,
    output logic [`XLEN-1:0] imm_ext
);

    // all formats take the sign from bit 31
    always_comb begin
        case (imm_src)
            // addi, lw
            imm_i: imm_ext = {{20{instr[31]}}, instr[31:20]};
            // sw, offset split around rd field
            imm_s: imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // beq, halfword offset with implied lsb
            imm_b: imm_ext = {{20{instr[31]}}, instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            // jal, 20-bit scrambled offset
            imm_j: imm_ext = {{12{instr[31]}}, instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            default: imm_ext = '0;
        endcase
    end

endmodule

// File: hdl/rv_alu.sv
`timescale 1ns/10ps

`include "rv_settings.svh"

module rv_alu
    import rv_pkg::*;
(
    input  logic [`XLEN-1:0] src_a,
    input  logic [`XLEN-1:0] src_b,
    input  alu_op_e          alu_control,
    output logic [`XLEN-1:0] result,
    output logic             zero
);

    // signed less-than for slt
    logic lt;

    assign lt = $signed(src_a) < $signed(src_b);

    // ------------------------------------------------------------------------
    // operation select
    // ------------------------------------------------------------------------
    always_comb begin
        case (alu_control)
            alu_add: result = src_a + src_b;
            // also used by beq, zero means equal
            alu_sub: result = src_a - src_b;
            alu_and: result = src_a & src_b;
            alu_or:  result = src_a | src_b;
            // 1 in bit 0, rest cleared
            alu_slt: result = {{(`XLEN-1){1'b0}}, lt};
            default: result = '0;
        endcase
    end

    // flag for branch decision
    assign zero = (result == '0);

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/10ps

`include "rv_settings.svh"

module rv_regfile (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] a1,
    input  logic [`REG_ADDR_W-1:0] a2,
    input  logic [`REG_ADDR_W-1:0] a3,
    input  logic [`XLEN-1:0]       wd3,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2
);

    // x0..x31
    logic [`XLEN-1:0] regs [1 << `REG_ADDR_W];

    // write port, x0 never written
    always_ff @(posedge clk) begin
        if (we && (a3 != '0)) begin
            regs[a3] <= wd3;
        end
    end

    // read ports are combinational
    // x0 decoded here so it reads zero from the first cycle
    always_comb begin
        rd1 = (a1 == '0) ? '0 : regs[a1];
        rd2 = (a2 == '0) ? '0 : regs[a2];
    end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    // ------------------------------------------------------------------------
    // major opcode classes, bits [6:0] of the instruction
    // ------------------------------------------------------------------------
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_i      = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    // ------------------------------------------------------------------------
    // alu operations
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_or  = 3'b011,
        alu_slt = 3'b101
    } alu_op_e;

    // immediate layout selected by the decoder
    typedef enum logic [1:0] {
        imm_i = 2'b00,
        imm_s = 2'b01,
        imm_b = 2'b10,
        imm_j = 2'b11
    } imm_src_e;

    // write-back source for the register file
    typedef enum logic [1:0] {
        res_alu = 2'b00,
        res_mem = 2'b01,
        res_pc4 = 2'b10
    } result_src_e;

endpackage

// File: include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data word width
`define XLEN 32

// byte address held in the program counter
`define PC_WIDTH 16

// memory depths in 32-bit words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// register index
`define REG_ADDR_W 5

`endif
